//--- hw/scott_pkg.sv
/*
 * scott_pkg: shared types for the 8-bit step-driven teaching cpu
 * opcodes, step states, flags, control word and bus records
 */
package scott_pkg;

	localparam int data_w = 8;	// data, address and instruction width

	// alu group, instruction bits 6:4 with bit 7 set
	typedef enum logic [2:0] {
		ADD, SHR, SHL, NOT, AND, OR, XOR, CMP
	} alu_op_e;

	// non-alu classes, bits 6:4 with bit 7 clear
	typedef enum logic [2:0] {
		LD, ST, DATA, JMPR, JMP, JCAEZ, CLF, IO
	} instr_class_e;

	typedef enum logic [2:0] {
		STEP1, STEP2, STEP3, STEP4, STEP5, STEP6
	} step_e;

	// bit order matches the jcaez mask in instruction bits 3:0
	typedef struct packed {
		logic carry;
		logic a_larger;
		logic equal;
		logic zero;
	} flags_t;

	typedef struct packed {
		logic       en_reg;		// gp register onto bus
		logic [1:0] en_reg_sel;
		logic       set_reg;		// bus into gp register
		logic [1:0] set_reg_sel;
		logic       en_ram;
		logic       en_iar;
		logic       en_acc;
		logic       en_io;
		logic       set_ir;
		logic       set_mar;
		logic       set_iar;
		logic       set_acc;
		logic       set_tmp;
		logic       set_flags;
		logic       set_io;
		logic       bus1;		// constant 1 on alu b side
		alu_op_e    alu_op;
		logic       alu_en;		// op comes from the instruction, carry chains in
		logic       mem_req;
		logic       mem_we;
		logic       io_is_output;
		logic       io_is_address;
	} ctrl_word_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [data_w-1:0] adr;
		logic [data_w-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic              valid;	// one cycle per output instruction
		logic              is_address;
		logic [data_w-1:0] data;
	} io_port_t;

endpackage

//--- hw/step_sequencer.sv
/*
 * step sequencer: counts steps one to six, one per clock,
 * stalls while a memory cycle is outstanding
 */
module step_sequencer (
	input  logic             sys_clk,
	input  logic             reset,
	input  logic             mem_busy,
	output scott_pkg::step_e step
);
	import scott_pkg::*;

	step_e step_next;

	// wrap after the last execute step
	always_comb begin
		if (step == STEP6)
			step_next = STEP1;
		else
			step_next = step_e'(step + 3'd1);
	end

	always_ff @(posedge sys_clk) begin
		if (reset)
			step <= STEP1;
		else if (!mem_busy)		// hold the step until ack
			step <= step_next;
	end

endmodule

//--- hw/control_decoder.sv
/*
 * control decoder: step x instruction x flags table
 * produces the enables and sets for the current step, purely combinational
 */
module control_decoder (
	input  scott_pkg::step_e      step,
	input  logic [7:0]            instruction,
	input  scott_pkg::flags_t     flags,
	output scott_pkg::ctrl_word_t ctrl
);
	import scott_pkg::*;

	logic         is_alu;
	instr_class_e cls;
	logic [1:0]   ra;
	logic [1:0]   rb;
	logic         jump_taken;

	assign is_alu = instruction[7];
	assign cls = instr_class_e'(instruction[6:4]);
	assign ra = instruction[3:2];
	assign rb = instruction[1:0];
	assign jump_taken = |(instruction[3:0] & flags);	// any selected flag

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = ADD;		// increment path uses add
		ctrl.set_reg_sel = rb;		// every register write targets rb
		case (step)
			STEP1: begin			// mar <- iar, acc <- iar + 1
				ctrl.bus1 = 1'b1;
				ctrl.en_iar = 1'b1;
				ctrl.set_mar = 1'b1;
				ctrl.set_acc = 1'b1;
			end
			STEP2: begin			// instruction fetch
				ctrl.en_ram = 1'b1;
				ctrl.mem_req = 1'b1;
				ctrl.set_ir = 1'b1;
			end
			STEP3: begin			// iar <- acc
				ctrl.en_acc = 1'b1;
				ctrl.set_iar = 1'b1;
			end
			STEP4: begin
				if (is_alu) begin
					ctrl.en_reg = 1'b1;	// rb into tmp
					ctrl.en_reg_sel = rb;
					ctrl.set_tmp = 1'b1;
				end else begin
					case (cls)
						LD, ST: begin		// address register to mar
							ctrl.en_reg = 1'b1;
							ctrl.en_reg_sel = ra;
							ctrl.set_mar = 1'b1;
						end
						DATA, JCAEZ: begin	// point at second byte, bump iar
							ctrl.bus1 = 1'b1;
							ctrl.en_iar = 1'b1;
							ctrl.set_mar = 1'b1;
							ctrl.set_acc = 1'b1;
						end
						JMPR: begin
							ctrl.en_reg = 1'b1;
							ctrl.en_reg_sel = rb;
							ctrl.set_iar = 1'b1;
						end
						JMP: begin
							ctrl.en_iar = 1'b1;
							ctrl.set_mar = 1'b1;
						end
						CLF: begin		// 0 + 1, carry masked, clears all flags
							ctrl.bus1 = 1'b1;
							ctrl.set_flags = 1'b1;
						end
						default: begin		// io select phase, output drives rb
							ctrl.en_reg = instruction[3];
							ctrl.en_reg_sel = rb;
							ctrl.set_io = 1'b1;
							ctrl.io_is_output = instruction[3];
							ctrl.io_is_address = instruction[2];
						end
					endcase
				end
			end
			STEP5: begin
				if (is_alu) begin
					ctrl.en_reg = 1'b1;	// ra on the a side
					ctrl.en_reg_sel = ra;
					ctrl.alu_op = alu_op_e'(instruction[6:4]);
					ctrl.alu_en = 1'b1;
					ctrl.set_acc = 1'b1;
					ctrl.set_flags = 1'b1;
				end else begin
					case (cls)
						LD, DATA: begin
							ctrl.en_ram = 1'b1;
							ctrl.mem_req = 1'b1;
							ctrl.set_reg = 1'b1;
						end
						ST: begin		// write rb to ram at mar
							ctrl.en_reg = 1'b1;
							ctrl.en_reg_sel = rb;
							ctrl.mem_req = 1'b1;
							ctrl.mem_we = 1'b1;
						end
						JMP: begin
							ctrl.en_ram = 1'b1;
							ctrl.mem_req = 1'b1;
							ctrl.set_iar = 1'b1;
						end
						JCAEZ: begin
							ctrl.set_iar = 1'b1;
							ctrl.en_ram = jump_taken;	// target byte
							ctrl.mem_req = jump_taken;
							ctrl.en_acc = ~jump_taken;	// skip the target
						end
						IO: begin		// input lands in rb
							ctrl.en_io = ~instruction[3];
							ctrl.set_reg = ~instruction[3];
						end
						default: ;
					endcase
				end
			end
			STEP6: begin
				if (is_alu) begin
					ctrl.en_acc = 1'b1;
					ctrl.set_reg = (instruction[6:4] != CMP);	// cmp keeps rb
				end else if (cls == DATA) begin
					ctrl.en_acc = 1'b1;	// iar past the data byte
					ctrl.set_iar = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- hw/alu.sv
/*
 * alu: eight 8-bit operations with carry in
 * result plus carry, a_larger, equal and zero flags
 */
module alu (
	input  scott_pkg::alu_op_e op,
	input  logic [7:0]         a,
	input  logic [7:0]         b,
	input  logic               carry_in,
	output logic [7:0]         result,
	output scott_pkg::flags_t  flags_out
);
	import scott_pkg::*;

	logic carry_out;

	always_comb begin
		carry_out = 1'b0;
		case (op)
			ADD: {carry_out, result} = a + b + carry_in;
			SHR: {result, carry_out} = {carry_in, a};	// lsb out to carry
			SHL: {carry_out, result} = {a, carry_in};	// msb out to carry
			NOT: result = ~a;
			AND: result = a & b;
			OR:  result = a | b;
			XOR: result = a ^ b;
			CMP: result = a ^ b;	// result dropped, flags only
			default: result = 8'h00;
		endcase
	end

	// compare always a against b, zero from the result
	assign flags_out.carry = carry_out;
	assign flags_out.a_larger = (a > b);
	assign flags_out.equal = (a == b);
	assign flags_out.zero = (result == 8'h00);

endmodule

//--- hw/datapath.sv
/*
 * datapath: r0-r3, ir, iar, acc, tmp, mar and flags around one internal bus
 * enables pick the bus source, sets load at the clock edge
 */
module datapath (
	input  logic                  sys_clk,
	input  logic                  reset,
	input  scott_pkg::ctrl_word_t ctrl,
	input  logic [7:0]            mem_rdata,
	input  logic                  mem_done,
	input  logic [7:0]            io_in,
	input  logic [7:0]            result,
	input  scott_pkg::flags_t     alu_flags,
	output logic [7:0]            alu_a,
	output logic [7:0]            alu_b,
	output logic                  carry_in,
	output logic [7:0]            instruction,
	output scott_pkg::flags_t     flags,
	output logic [7:0]            mar,
	output logic [7:0]            bus_data,
	output scott_pkg::io_port_t   io_out
);
	logic [7:0] regs [4];		// r0..r3
	logic [7:0] iar;
	logic [7:0] acc;
	logic [7:0] tmp;
	logic       io_valid;
	logic       io_is_address;
	logic [7:0] io_data;
	logic       go;

	// memory step freezes all sets until ack
	assign go = ~ctrl.mem_req | mem_done;

	// one source at a time, idle bus reads as zero
	always_comb begin
		if (ctrl.en_ram)
			bus_data = mem_rdata;
		else if (ctrl.en_iar)
			bus_data = iar;
		else if (ctrl.en_acc)
			bus_data = acc;
		else if (ctrl.en_io)
			bus_data = io_in;
		else if (ctrl.en_reg)
			bus_data = regs[ctrl.en_reg_sel];
		else
			bus_data = 8'h00;
	end

	assign alu_a = bus_data;
	assign alu_b = ctrl.bus1 ? 8'd1 : tmp;
	assign carry_in = ctrl.alu_en & flags.carry;	// no carry on increments or clf

	// architectural state and io strobe
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			regs <= '{default: 8'h00};
			iar <= 8'h00;		// first fetch from 0
			flags <= '0;
			io_valid <= 1'b0;
		end else begin
			if (go && ctrl.set_reg)
				regs[ctrl.set_reg_sel] <= bus_data;
			if (go && ctrl.set_iar)
				iar <= bus_data;
			if (go && ctrl.set_flags)
				flags <= alu_flags;
			io_valid <= go & ctrl.set_io & ctrl.io_is_output;	// single pulse
		end
	end

	// working registers
	always_ff @(posedge sys_clk) begin
		if (go) begin
			if (ctrl.set_ir)
				instruction <= bus_data;
			if (ctrl.set_mar)
				mar <= bus_data;
			if (ctrl.set_acc)
				acc <= result;
			if (ctrl.set_tmp)
				tmp <= bus_data;
			if (ctrl.set_io && ctrl.io_is_output) begin
				io_data <= bus_data;
				io_is_address <= ctrl.io_is_address;
			end
		end
	end

	assign io_out.valid = io_valid;
	assign io_out.is_address = io_is_address;
	assign io_out.data = io_data;

endmodule

//--- hw/wb_mem_master.sv
/*
 * wishbone classic master: one read or write per memory step
 * busy until ack, done in the ack cycle
 */
module wb_mem_master (
	input  logic               sys_clk,
	input  logic               reset,
	input  logic               mem_req,
	input  logic               mem_we,
	input  logic [7:0]         adr,
	input  logic [7:0]         dat_w,
	input  logic [7:0]         wb_dat_r,
	input  logic               wb_ack,
	output scott_pkg::wb_req_t wb_out,
	output logic               mem_busy,
	output logic               mem_done,
	output logic [7:0]         mem_rdata
);
	logic       active;		// cyc and stb
	logic       we_q;
	logic [7:0] adr_q;
	logic [7:0] dat_q;

	assign mem_done = active & wb_ack;
	assign mem_busy = mem_req & ~mem_done;
	assign mem_rdata = wb_dat_r;	// taken by the destination at the ack edge

	always_ff @(posedge sys_clk) begin
		if (reset)
			active <= 1'b0;
		else if (mem_done)
			active <= 1'b0;		// drop right after ack
		else if (mem_req)
			active <= 1'b1;
	end

	// request held stable for the whole cycle
	always_ff @(posedge sys_clk) begin
		if (mem_req && !active) begin
			adr_q <= adr;
			we_q <= mem_we;
			dat_q <= dat_w;
		end
	end

	assign wb_out.cyc = active;
	assign wb_out.stb = active;
	assign wb_out.we = active & we_q;
	assign wb_out.adr = adr_q;
	assign wb_out.dat_w = dat_q;

endmodule

//--- hw/scott_cpu.sv
/*
 * scott_cpu: top of the 8-bit step-driven cpu
 * sequencer, decoder, datapath, alu and wishbone master
 */
module scott_cpu (
	input  logic                sys_clk,
	input  logic                reset,
	output scott_pkg::wb_req_t  wb_out,
	input  logic [7:0]          wb_dat_r,
	input  logic                wb_ack,
	input  logic [7:0]          io_in,
	output scott_pkg::io_port_t io_out
);
	import scott_pkg::*;

	step_e      step;
	ctrl_word_t ctrl;
	flags_t     flags;
	flags_t     alu_flags;
	logic [7:0] instruction;
	logic [7:0] alu_a;
	logic [7:0] alu_b;
	logic [7:0] result;
	logic [7:0] mar;
	logic [7:0] bus_data;
	logic [7:0] mem_rdata;
	logic       carry_in;
	logic       mem_busy;
	logic       mem_done;

	step_sequencer u_step_sequencer (
		.sys_clk  (sys_clk),
		.reset    (reset),
		.mem_busy (mem_busy),
		.step     (step)
	);

	control_decoder u_control_decoder (
		.step        (step),
		.instruction (instruction),
		.flags       (flags),
		.ctrl        (ctrl)
	);

	alu u_alu (
		.op        (ctrl.alu_op),
		.a         (alu_a),
		.b         (alu_b),
		.carry_in  (carry_in),
		.result    (result),
		.flags_out (alu_flags)
	);

	datapath u_datapath (
		.sys_clk     (sys_clk),
		.reset       (reset),
		.ctrl        (ctrl),
		.mem_rdata   (mem_rdata),
		.mem_done    (mem_done),
		.io_in       (io_in),
		.result      (result),
		.alu_flags   (alu_flags),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.carry_in    (carry_in),
		.instruction (instruction),
		.flags       (flags),
		.mar         (mar),
		.bus_data    (bus_data),
		.io_out      (io_out)
	);

	wb_mem_master u_wb_mem_master (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.mem_req   (ctrl.mem_req),
		.mem_we    (ctrl.mem_we),
		.adr       (mar),		// address always from mar
		.dat_w     (bus_data),	// store data rides the bus
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.wb_out    (wb_out),
		.mem_busy  (mem_busy),
		.mem_done  (mem_done),
		.mem_rdata (mem_rdata)
	);

endmodule

//--- tests/cpu_ref_model.svh
/*
 * instruction-level reference model of the cpu isa
 * runs the memory image and records expected bus cycles and io outputs in order
 */
logic [7:0] ref_mem [256];
logic [7:0] ref_regs [4];
logic [7:0] ref_iar;
flags_t     ref_flags;
int         ref_instr_count;
logic       ref_halted;		// self-jump reached
logic [7:0] exp_adr [$];	// every bus cycle, fetches included
logic       exp_we [$];
logic [7:0] exp_dat [$];	// write data only
logic       exp_io_apply [$];	// fetch of an io input instruction
logic [8:0] exp_io [$];		// {is_address, data}

// returns {flags, result}
function automatic logic [11:0] alu_model(input alu_op_e op, input logic [7:0] a,
		input logic [7:0] b, input logic cin);
	logic [8:0] sum;
	logic [7:0] res;
	logic       c;
	c = 1'b0;
	sum = {1'b0, a} + {1'b0, b} + {8'h00, cin};
	case (op)
		ADD: begin
			res = sum[7:0];
			c = sum[8];
		end
		SHR: begin		// carry in at the top
			res = {cin, a[7:1]};
			c = a[0];
		end
		SHL: begin
			res = {a[6:0], cin};
			c = a[7];
		end
		NOT: res = ~a;
		AND: res = a & b;
		OR:  res = a | b;
		XOR: res = a ^ b;
		default: res = a ^ b;	// compare, zero means equal
	endcase
	return {c, a > b, a == b, res == 8'h00, res};
endfunction

task automatic expect_read(input logic [7:0] adr, input logic apply);
	exp_adr.push_back(adr);
	exp_we.push_back(1'b0);
	exp_dat.push_back(8'h00);
	exp_io_apply.push_back(apply);
endtask

task automatic expect_write(input logic [7:0] adr, input logic [7:0] dat);
	exp_adr.push_back(adr);
	exp_we.push_back(1'b1);
	exp_dat.push_back(dat);
	exp_io_apply.push_back(1'b0);
endtask

task automatic model_run(input int max_instr);
	logic [7:0]  pc;
	logic [7:0]  ir;
	logic [11:0] alu_out;
	logic [1:0]  ra;
	logic [1:0]  rb;
	int          in_idx;
	ref_mem = image;
	ref_regs = '{default: 8'h00};
	ref_iar = 8'h00;
	ref_flags = '0;
	ref_halted = 1'b0;
	ref_instr_count = 0;
	in_idx = 0;
	exp_adr.delete();
	exp_we.delete();
	exp_dat.delete();
	exp_io_apply.delete();
	exp_io.delete();
	while (!ref_halted && ref_instr_count < max_instr) begin
		pc = ref_iar;
		ir = ref_mem[pc];
		ra = ir[3:2];
		rb = ir[1:0];
		ref_iar = pc + 8'd1;
		expect_read(pc, ir[7:3] == 5'b01110);	// io input takes the next io_in
		ref_instr_count++;
		if (ir[7]) begin
			alu_out = alu_model(alu_op_e'(ir[6:4]), ref_regs[ra], ref_regs[rb], ref_flags.carry);
			ref_flags = alu_out[11:8];
			if (alu_op_e'(ir[6:4]) != CMP)
				ref_regs[rb] = alu_out[7:0];
		end else begin
			case (instr_class_e'(ir[6:4]))
				LD: begin
					expect_read(ref_regs[ra], 1'b0);
					ref_regs[rb] = ref_mem[ref_regs[ra]];
				end
				ST: begin
					expect_write(ref_regs[ra], ref_regs[rb]);
					ref_mem[ref_regs[ra]] = ref_regs[rb];
				end
				DATA: begin		// second byte into rb
					expect_read(ref_iar, 1'b0);
					ref_regs[rb] = ref_mem[ref_iar];
					ref_iar = ref_iar + 8'd1;
				end
				JMPR: ref_iar = ref_regs[rb];
				JMP: begin
					expect_read(ref_iar, 1'b0);
					ref_halted = (ref_mem[ref_iar] == pc);
					ref_iar = ref_mem[ref_iar];
				end
				JCAEZ: begin
					if ((ir[3:0] & ref_flags) != 4'h0) begin
						expect_read(ref_iar, 1'b0);
						ref_iar = ref_mem[ref_iar];
					end else
						ref_iar = ref_iar + 8'd1;	// skip the target byte
				end
				CLF: ref_flags = '0;
				default: begin
					if (ir[3])
						exp_io.push_back({ir[2], ref_regs[rb]});
					else begin
						ref_regs[rb] = io_vals[in_idx];
						in_idx = (in_idx + 1) % 64;
					end
				end
			endcase
		end
	end
endtask

//--- tests/tb_scott_cpu.sv
/*
 * testbench for scott_cpu: random programs from a seeded xorshift,
 * wishbone memory with random wait states, io responder, model compare
 */
module tb_scott_cpu;
	timeunit 1ns;
	timeprecision 1ps;
	import scott_pkg::*;

	logic       sys_clk;
	logic       reset;
	logic [7:0] wb_dat_r;
	logic       wb_ack;
	logic [7:0] io_in;
	wb_req_t    wb_out;
	io_port_t   io_out;

	logic [7:0]  image [256];	// program as generated
	logic [7:0]  mem [256];		// memory seen by the dut
	logic [7:0]  io_vals [64];	// io_in values, in order of use
	logic [31:0] rng_state;
	int          gen_pc;
	int          fail_count;
	int          check_count;
	int          test_count;
	logic        timed_out;

	`include "cpu_ref_model.svh"

	scott_cpu u_dut (
		.sys_clk  (sys_clk),
		.reset    (reset),
		.wb_out   (wb_out),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.io_in    (io_in),
		.io_out   (io_out)
	);

	always #2 sys_clk = ~sys_clk;

	function automatic logic [7:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state[7:0];
	endfunction

	task automatic check_value(input string label, input logic [7:0] expected,
			input logic [7:0] actual);
		check_count++;
		assert (expected === actual) else begin
			$display("CHECK FAILED %s: expected %02h, actual %02h", label, expected, actual);
			fail_count++;
		end
	endtask

	task automatic check_condition(input logic ok, input string what);
		check_count++;
		assert (ok) else begin
			$display("%s", what);
			fail_count++;
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (fail_count == fails_before)
			$display("test %s: pass", name);
		else
			$display("test %s: fail, %0d failed checks", name, fail_count - fails_before);
	endtask

	task automatic emit(input logic [7:0] b);
		image[gen_pc] = b;
		gen_pc++;
	endtask

	task automatic emit_halt();
		logic [7:0] here;
		here = 8'(gen_pc);
		emit(8'h40);		// jmp to itself
		emit(here);
	endtask

	task automatic clear_image();
		for (int i = 0; i < 256; i++)
			image[i] = 8'(i * 37 + 11);	// background from the full address
		gen_pc = 0;
	endtask

	task automatic build_alu_program();
		logic [1:0] ra;
		logic [1:0] rb;
		clear_image();
		for (int n = 0; n < 16; n++) begin
			ra = 2'(next_random());
			rb = 2'(next_random());
			emit({6'b001000, ra});
			emit(next_random());
			emit({6'b001000, rb});
			emit(next_random());
			emit({1'b1, 3'(next_random()), ra, rb});	// flags carry across blocks
			emit({6'b011110, rb});			// out data rb
		end
		emit_halt();
	endtask

	task automatic build_memory_program();
		clear_image();
		for (int i = 8'hc0; i < 256; i++)
			image[i] = next_random();	// data region
		for (int n = 0; n < 12; n++) begin
			emit(8'h20);
			emit({2'b11, 6'(next_random())});	// store address
			emit(8'h21);
			emit(next_random());
			emit(8'h11);		// st [r0] <- r1
			emit(8'h22);
			emit({2'b11, 6'(next_random())});	// load address
			emit(8'h0b);		// ld r3 <- [r2]
			emit(8'h7b);		// out r3
		end
		emit_halt();
	endtask

	task automatic build_branch_program();
		logic [7:0] x;
		logic [7:0] y;
		clear_image();
		for (int n = 0; n < 14; n++) begin
			case (next_random() % 8'd3)
				8'd0: begin
					x = next_random();
					y = next_random();
					emit(8'h20);
					emit(x);
					emit(8'h21);
					emit(y[0] ? x : y);	// equal about half the time
					emit(8'hf1);		// cmp r0, r1
					emit({4'h5, 4'(next_random())});
					emit(8'(gen_pc + 2));
					emit(8'h79);		// runs only when not taken
				end
				8'd1: begin
					emit(8'h40);
					emit(8'(gen_pc + 2));
					emit(8'h78);		// jumped over
				end
				default: begin
					emit(8'h22);
					emit(8'(gen_pc + 3));
					emit(8'h32);		// jmpr r2
					emit(8'h79);
				end
			endcase
		end
		emit_halt();
	endtask

	task automatic build_io_program();
		logic [1:0] rb;
		clear_image();
		for (int i = 0; i < 64; i++)
			io_vals[i] = next_random();
		for (int n = 0; n < 20; n++) begin
			rb = 2'(next_random());
			emit({5'b01110, 1'(next_random()), rb});	// input into rb
			emit({5'b01111, 1'(next_random()), rb});	// output, bit 2 picks address
		end
		emit_halt();
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		wb_ack = 1'b0;
		repeat (4)
			@(posedge sys_clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic check_reset_state();
		int cycles;
		int fails_before;
		fails_before = fail_count;
		test_count++;
		reset = 1'b1;
		repeat (4) begin
			@(posedge sys_clk);
			#1;
			check_condition(!wb_out.cyc && !wb_out.stb && !io_out.valid,
				"reset_state: bus or io active during reset");
		end
		reset = 1'b0;
		cycles = 0;
		while (!wb_out.cyc && !timed_out) begin
			@(posedge sys_clk);
			#1;
			cycles++;
			check_condition(wb_out.cyc == wb_out.stb && !io_out.valid,
				"reset_state: io or stb active before the first fetch");
			if (cycles > (6 + 3 * 3) * 2) begin
				$display("timeout: reset_state saw no fetch within %0d cycles", cycles);
				fail_count++;
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			check_value("reset_state first fetch adr", 8'h00, wb_out.adr);
			check_value("reset_state first fetch we", 8'h00, {7'h0, wb_out.we});
		end
		report_test("reset_state", fails_before);
	endtask

	// dut against model, cycle by cycle at 1 ns after the edge
	task automatic run_program(input string name);
		int      limit;
		int      cycles;
		int      idx;
		int      io_idx;
		int      in_idx;
		int      wait_left;
		int      fails_before;
		logic    in_cycle;
		logic    acking;
		logic    done;
		wb_req_t first;
		fails_before = fail_count;
		test_count++;
		model_run(500);
		check_condition(ref_halted, {name, ": reference model never reached the halt jump"});
		limit = ref_instr_count * (6 + 3 * 3) * 2;
		mem = image;
		cycles = 0;
		idx = 0;
		io_idx = 0;
		in_idx = 0;
		wait_left = 0;
		in_cycle = 1'b0;
		acking = 1'b0;
		done = 1'b0;
		apply_reset();
		while (!done) begin
			@(posedge sys_clk);
			#1;
			cycles++;
			if (io_out.valid) begin
				if (io_idx < exp_io.size()) begin
					check_value({name, " io data"}, exp_io[io_idx][7:0], io_out.data);
					check_value({name, " io is_address"}, {7'h0, exp_io[io_idx][8]},
						{7'h0, io_out.is_address});
				end else
					check_condition(1'b0, {name, ": io output beyond the predicted sequence"});
				io_idx++;
			end
			if (acking) begin		// cycle closed at the last edge
				wb_ack = 1'b0;
				acking = 1'b0;
				in_cycle = 1'b0;
				check_condition(!wb_out.cyc && !wb_out.stb, {name, ": cyc or stb high after ack"});
				done = (idx >= exp_adr.size());
			end else if (wb_out.cyc) begin
				if (!in_cycle) begin
					in_cycle = 1'b1;
					first = wb_out;
					wait_left = int'(next_random() % 8'd4);
					if (idx < exp_adr.size()) begin
						check_value({name, " bus adr"}, exp_adr[idx], wb_out.adr);
						check_value({name, " bus we"}, {7'h0, exp_we[idx]}, {7'h0, wb_out.we});
						if (exp_we[idx])
							check_value({name, " write data"}, exp_dat[idx], wb_out.dat_w);
					end else begin
						check_condition(1'b0, {name, ": bus cycle beyond the predicted trace"});
						done = 1'b1;
					end
				end else
					check_condition(wb_out == first, {name, ": request changed during wait states"});
				if (wait_left == 0) begin
					if (wb_out.we)
						mem[wb_out.adr] = wb_out.dat_w;
					else
						wb_dat_r = mem[wb_out.adr];
					if (idx < exp_adr.size() && exp_io_apply[idx]) begin
						io_in = io_vals[in_idx];	// held until the next io input fetch
						in_idx = (in_idx + 1) % 64;
					end
					wb_ack = 1'b1;
					acking = 1'b1;
					idx++;
				end else
					wait_left--;
			end else
				check_condition(!in_cycle, {name, ": cycle dropped before ack"});
			if (cycles > limit && !done) begin
				$display("timeout: test %s did not finish within %0d cycles", name, limit);
				fail_count++;
				timed_out = 1'b1;
				done = 1'b1;
			end
		end
		if (!timed_out)
			check_condition(io_idx == exp_io.size(), {name, ": fewer io outputs than predicted"});
		report_test(name, fails_before);
	endtask

	initial begin
		sys_clk = 1'b0;
		reset = 1'b1;
		wb_dat_r = 8'h00;
		wb_ack = 1'b0;
		io_in = 8'h00;
		rng_state = 32'd7;
		fail_count = 0;
		check_count = 0;
		test_count = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 64; i++)
			io_vals[i] = 8'h00;
		check_reset_state();
		if (!timed_out) begin
			build_alu_program();
			run_program("alu_program");
		end
		if (!timed_out) begin
			build_memory_program();
			run_program("memory");
		end
		if (!timed_out) begin
			build_branch_program();
			run_program("branches");
		end
		if (!timed_out) begin
			build_io_program();
			run_program("io");
		end
		$display("summary: %0d tests, %0d checks, %0d failed", test_count, check_count, fail_count);
		if (fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- scott_cpu.f
+incdir+tests
hw/scott_pkg.sv
hw/step_sequencer.sv
hw/control_decoder.sv
hw/alu.sv
hw/datapath.sv
hw/wb_mem_master.sv
hw/scott_cpu.sv
tests/tb_scott_cpu.sv

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the scott_cpu testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_scott_cpu -f scott_cpu.f --Mdir obj_dir -o tb_scott_cpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_scott_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
